// File: build.f
uart_pkg.sv
fifo_if.sv
baud_tick_gen.sv
fifo_transmitter.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
tb_uart_top.sv

// File: Bender.yml
package:
  name: uart_top

sources:
  - uart_pkg.sv
  - fifo_if.sv
  - baud_tick_gen.sv
  - fifo_transmitter.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_top.sv
  - target: simulation
    files:
      - tb_uart_top.sv

// File: tb_uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uart_top;

    localparam int FRAME_CLKS     = 10 * 16 * 4; // 8N1 frame at BAUD_DIV 4
    localparam int BANG_CLKS      = 64;          // clocks per bit on the bit-bang line
    localparam int TIMEOUT_CYCLES = 40000;       // ~30 frames of FRAME_CLKS plus margin
    localparam int TBL_LEN        = 6;
    localparam int STREAM_LEN     = 12;
    localparam int BURST_LEN      = 5;           // one more than BAUD_DIV so a pop meets a write

    logic       i_clk;
    logic       i_reset;
    logic       i_tx_wr;
    logic [7:0] i_tx_data;
    logic       o_tx_full;
    logic       o_tx_empty;
    logic       o_txd;
    logic [7:0] o_rx_data;
    logic       o_rx_valid;
    logic       o_rx_frame_err;

    logic loopback_sel; // 1 routes o_txd back and 0 uses bang_bit
    logic bang_bit;
    wire  rxd_line;

    // byte and gap in clocks with gaps longer than one frame
    logic [7:0] tbl_byte [TBL_LEN] = '{8'h55, 8'hA5, 8'h00, 8'hFF, 8'h3C, 8'h81};
    int         tbl_gap  [TBL_LEN] = '{700, 720, 660, 800, 690, 750};

    logic [7:0] exp_data_q [$];
    logic       exp_err_q  [$];
    logic [7:0] exp_byte;
    logic       exp_err;

    int          err_cnt;
    int          test_err_base;
    int          tests_run;
    int          tests_failed;
    int          rx_cnt;
    int          rx_base;
    int          cycle_cnt;
    logic [31:0] lcg_state;
    logic [15:0] rnd_val;
    int          gap_clks;

    assign rxd_line = loopback_sel ? o_txd : bang_bit;

    uart_top UUT (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_tx_wr        (i_tx_wr),
        .i_tx_data      (i_tx_data),
        .o_tx_full      (o_tx_full),
        .o_tx_empty     (o_tx_empty),
        .o_txd          (o_txd),
        .i_rxd          (rxd_line),
        .o_rx_data      (o_rx_data),
        .o_rx_valid     (o_rx_valid),
        .o_rx_frame_err (o_rx_frame_err)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (err_cnt == test_err_base) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s (%0d errors)", name, err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    // write strobe held from this edge to the next
    task automatic push_byte(input logic [7:0] data);
        @(posedge i_clk);
        i_tx_wr   <= 1'b1;
        i_tx_data <= data;
    endtask

    task automatic release_write();
        @(posedge i_clk);
        i_tx_wr <= 1'b0;
    endtask

    task automatic wait_rx_drain();
        while (exp_data_q.size() != 0) @(negedge i_clk);
    endtask

    // one frame on the bit-bang line with the start bit first
    task automatic bang_frame(input logic [7:0] data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        exp_data_q.push_back(data);
        exp_err_q.push_back(~stop_bit);
        for (int b = 0; b < 10; b++) begin
            @(posedge i_clk);
            bang_bit <= frame[b];
            repeat (BANG_CLKS - 1) @(posedge i_clk);
        end
        @(posedge i_clk);
        bang_bit <= 1'b1;
    endtask

    // scoreboard of accepted writes and valid pulses
    always @(posedge i_clk) begin
        if (!i_reset && i_tx_wr && !o_tx_full) begin
            exp_data_q.push_back(i_tx_data);
            exp_err_q.push_back(1'b0);
        end
        if (!i_reset && o_rx_valid) begin
            rx_cnt++;
            if (exp_data_q.size() == 0) begin
                report_error($sformatf("unexpected byte %h received", o_rx_data));
            end else begin
                exp_byte = exp_data_q.pop_front();
                exp_err  = exp_err_q.pop_front();
                if (o_rx_data !== exp_byte)
                    report_error($sformatf("rx data %h, expected %h", o_rx_data, exp_byte));
                if (o_rx_frame_err !== exp_err)
                    report_error($sformatf("frame_err %b, expected %b", o_rx_frame_err, exp_err));
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, the receiver never finished", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        i_reset       = 1'b1;
        i_tx_wr       = 1'b0;
        i_tx_data     = 8'h00;
        loopback_sel  = 1'b1;
        bang_bit      = 1'b1;
        lcg_state     = 32'd80;
        err_cnt       = 0;
        test_err_base = 0;
        tests_run     = 0;
        tests_failed  = 0;
        rx_cnt        = 0;

        repeat (10) @(posedge i_clk);
        i_reset <= 1'b0;

        // reset state
        @(negedge i_clk);
        if (o_txd !== 1'b1) report_error("o_txd not high after reset");
        if (o_tx_empty !== 1'b1) report_error("o_tx_empty not set after reset");
        if (o_tx_full !== 1'b0) report_error("o_tx_full set after reset");
        if (o_rx_valid !== 1'b0) report_error("o_rx_valid high after reset");
        if (o_rx_frame_err !== 1'b0) report_error("o_rx_frame_err high after reset");
        close_test("reset state");

        for (int i = 0; i < TBL_LEN; i++) begin
            push_byte(tbl_byte[i]);
            release_write();
            repeat (tbl_gap[i]) @(posedge i_clk);
        end
        wait_rx_drain();
        close_test("table loopback");

        // prime byte keeps the serializer busy while the FIFO fills
        push_byte(8'hC3);
        release_write();
        @(negedge i_clk);
        while (o_tx_empty !== 1'b1) @(negedge i_clk);
        rx_base = rx_cnt;
        for (int i = 0; i < 9; i++) push_byte(8'h10 + i[7:0]);
        release_write();
        @(negedge i_clk);
        if (o_tx_full !== 1'b1) report_error("FIFO not full after eight writes");
        while (exp_data_q.size() != 0) begin
            @(negedge i_clk);
            if (o_tx_empty && (rx_cnt - rx_base) < 8)
                report_error("o_tx_empty rose before the last pop");
        end
        if (rx_cnt - rx_base != 9)
            report_error($sformatf("%0d bytes received, expected 9", rx_cnt - rx_base));
        if (o_tx_empty !== 1'b1) report_error("o_tx_empty low after the FIFO drained");
        close_test("fill and overflow");

        // serializer back in idle so the first pop falls inside the burst
        repeat (FRAME_CLKS / 10) @(posedge i_clk);
        for (int i = 0; i < BURST_LEN; i++) begin
            rnd_val = next_rand();
            push_byte(rnd_val[7:0]);
        end
        release_write();
        for (int i = 0; i < STREAM_LEN; i++) begin
            rnd_val = next_rand();
            push_byte(rnd_val[7:0]);
            release_write();
            rnd_val  = next_rand();
            gap_clks = rnd_val % 700;
            repeat (gap_clks) @(posedge i_clk);
        end
        wait_rx_drain();
        close_test("random streaming");

        @(posedge i_clk);
        loopback_sel <= 1'b0;
        repeat (BANG_CLKS) @(posedge i_clk);
        bang_frame(8'h96, 1'b0); // stop bit forced low
        wait_rx_drain();
        repeat (BANG_CLKS) @(posedge i_clk);
        bang_frame(8'h4B, 1'b1);
        wait_rx_drain();
        close_test("framing error");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: uart_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
    parameter int BAUD_DIV        = 4, // clocks per 16x tick
    parameter int FIFO_ADDR_WIDTH = 3  // 8 entry transmit FIFO
) (
    input  wire                   i_clk,
    input  wire                   i_reset,

    // host write side of the transmit FIFO
    input  wire                   i_tx_wr,
    input  wire uart_pkg::data_byte_t i_tx_data,
    output logic                  o_tx_full,
    output logic                  o_tx_empty,

    // serial lines
    output logic                  o_txd,
    input  wire                   i_rxd,

    // receive side
    output uart_pkg::data_byte_t  o_rx_data,
    output logic                  o_rx_valid,
    output logic                  o_rx_frame_err
);

    fifo_if tx_fifo_bus ();

    logic tick; // shared by both directions

    // writer side, host strobes go straight in
    assign tx_fifo_bus.wr      = i_tx_wr;
    assign tx_fifo_bus.wr_data = i_tx_data;
    assign o_tx_full           = tx_fifo_bus.full;
    assign o_tx_empty          = tx_fifo_bus.empty;

    baud_tick_gen #(
        .BAUD_DIV (BAUD_DIV)
    ) u_baud_tick_gen (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    fifo_transmitter #(
        .FIFO_ADDR_WIDTH (FIFO_ADDR_WIDTH)
    ) u_fifo_transmitter (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .f       (tx_fifo_bus.fifo)
    );

    uart_tx u_uart_tx (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_tick  (tick),
        .f       (tx_fifo_bus.reader),
        .o_txd   (o_txd)
    );

    uart_rx u_uart_rx (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_tick         (tick),
        .i_rxd          (i_rxd),
        .o_rx_data      (o_rx_data),
        .o_rx_valid     (o_rx_valid),
        .o_rx_frame_err (o_rx_frame_err)
    );

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                   i_clk,
    input  wire                   i_reset,
    input  wire                   i_tick,
    input  wire                   i_rxd,
    output uart_pkg::data_byte_t  o_rx_data,
    output logic                  o_rx_valid,
    output logic                  o_rx_frame_err
);

    localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);

    uart_pkg::rx_state_t  state;
    uart_pkg::tick_cnt_t  tick_cnt;
    logic [BIT_W-1:0]     bit_idx;
    uart_pkg::data_byte_t shift_reg;
    logic                 rxd_meta, rxd_sync, rxd_prev;
    logic                 fall_edge;
    logic                 bit_done;

    // two-flop synchronizer plus one stage for edge detect
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= i_rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall_edge = rxd_prev & ~rxd_sync;
    assign bit_done  = i_tick & (tick_cnt == uart_pkg::tick_cnt_t'(15));

    always_ff @(posedge i_clk) begin
        if (state == uart_pkg::RX_DATA && bit_done) begin
            shift_reg <= {rxd_sync, shift_reg[7:1]}; // LSB arrives first
        end
        if (state == uart_pkg::RX_STOP && bit_done) begin
            o_rx_data <= shift_reg;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state          <= uart_pkg::RX_IDLE;
            tick_cnt       <= '0;
            bit_idx        <= '0;
            o_rx_valid     <= 1'b0;
            o_rx_frame_err <= 1'b0;
        end else begin
            o_rx_valid     <= 1'b0;
            o_rx_frame_err <= 1'b0;
            case (state)
                uart_pkg::RX_IDLE: begin
                    if (fall_edge) begin
                        state    <= uart_pkg::RX_START;
                        tick_cnt <= '0;
                    end
                end
                uart_pkg::RX_START: begin
                    if (i_tick && tick_cnt == uart_pkg::tick_cnt_t'(7)) begin
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        // mid start bit, line back high means a glitch
                        state <= rxd_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        if (bit_idx == BIT_W'(uart_pkg::DATA_BITS - 1)) begin
                            state <= uart_pkg::RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (bit_done) begin
                        state          <= uart_pkg::RX_IDLE;
                        tick_cnt       <= '0;
                        o_rx_valid     <= 1'b1;
                        o_rx_frame_err <= ~rxd_sync; // stop must read 1
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire   i_clk,
    input  wire   i_reset,
    input  wire   i_tick,
    fifo_if.reader f,
    output logic  o_txd
);

    localparam int BIT_W = $clog2(uart_pkg::DATA_BITS);

    uart_pkg::tx_state_t  state;
    uart_pkg::tick_cnt_t  tick_cnt;
    logic [BIT_W-1:0]     bit_idx;
    uart_pkg::data_byte_t shift_reg;
    logic                 bit_done;

    // pop strobe only from idle on a tick
    assign f.rd = (state == uart_pkg::TX_IDLE) & ~f.empty & i_tick;

    assign bit_done = i_tick & (tick_cnt == uart_pkg::tick_cnt_t'(15));

    // frame payload
    always_ff @(posedge i_clk) begin
        if (f.rd) begin
            shift_reg <= f.rd_data; // latch head in the pop cycle
        end else if (state == uart_pkg::TX_DATA && bit_done) begin
            shift_reg <= {1'b0, shift_reg[7:1]}; // LSB first
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= uart_pkg::TX_IDLE;
            tick_cnt <= '0;
            bit_idx  <= '0;
            o_txd    <= 1'b1; // line idles high
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (f.rd) begin
                        state    <= uart_pkg::TX_START;
                        tick_cnt <= '0;
                        o_txd    <= 1'b0; // start bit
                    end
                end
                uart_pkg::TX_START: begin
                    if (bit_done) begin
                        state    <= uart_pkg::TX_DATA;
                        tick_cnt <= '0;
                        bit_idx  <= '0;
                        o_txd    <= shift_reg[0];
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        if (bit_idx == BIT_W'(uart_pkg::DATA_BITS - 1)) begin
                            state <= uart_pkg::TX_STOP;
                            o_txd <= 1'b1; // stop bit
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            o_txd   <= shift_reg[1]; // next bit after shift
                        end
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (bit_done) begin
                        state    <= uart_pkg::TX_IDLE;
                        tick_cnt <= '0;
                    end else if (i_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: fifo_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_transmitter #(
    parameter int FIFO_ADDR_WIDTH = 3 // depth is 2**FIFO_ADDR_WIDTH
) (
    input wire i_clk,
    input wire i_reset,
    fifo_if.fifo f
);

    localparam int DEPTH = 2 ** FIFO_ADDR_WIDTH;

    uart_pkg::data_byte_t fifo_mem [DEPTH];

    logic [FIFO_ADDR_WIDTH-1:0] wr_ptr, next_wr_ptr, succ_wr_ptr;
    logic [FIFO_ADDR_WIDTH-1:0] rd_ptr, next_rd_ptr, succ_rd_ptr;
    logic full_reg, empty_reg, next_full, next_empty;
    logic wr_en;

    assign wr_en = f.wr & ~full_reg; // writes while full are dropped

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            fifo_mem[wr_ptr] <= f.wr_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            full_reg  <= 1'b0;
            empty_reg <= 1'b1;
        end else begin
            wr_ptr    <= next_wr_ptr;
            rd_ptr    <= next_rd_ptr;
            full_reg  <= next_full;
            empty_reg <= next_empty;
        end
    end

    always_comb begin
        succ_wr_ptr = wr_ptr + 1'b1;
        succ_rd_ptr = rd_ptr + 1'b1;

        // hold by default
        next_wr_ptr = wr_ptr;
        next_rd_ptr = rd_ptr;
        next_full   = full_reg;
        next_empty  = empty_reg;

        case ({f.wr, f.rd})
            2'b01: begin // pop
                if (~empty_reg) begin
                    next_rd_ptr = succ_rd_ptr;
                    next_full   = 1'b0;
                    if (succ_rd_ptr == wr_ptr) begin
                        next_empty = 1'b1;
                    end
                end
            end
            2'b10: begin // push
                if (~full_reg) begin
                    next_wr_ptr = succ_wr_ptr;
                    next_empty  = 1'b0;
                    if (succ_wr_ptr == rd_ptr) begin
                        next_full = 1'b1;
                    end
                end
            end
            2'b11: begin
                if (empty_reg) begin
                    // nothing to pop, only the write lands
                    next_wr_ptr = succ_wr_ptr;
                    next_empty  = 1'b0;
                end else if (full_reg) begin
                    // no room, only the read lands
                    next_rd_ptr = succ_rd_ptr;
                    next_full   = 1'b0;
                end else begin
                    next_wr_ptr = succ_wr_ptr; // occupancy unchanged
                    next_rd_ptr = succ_rd_ptr;
                end
            end
            default: ;
        endcase
    end

    assign f.rd_data = fifo_mem[rd_ptr];
    assign f.full    = full_reg;
    assign f.empty   = empty_reg;

endmodule

`default_nettype wire

// File: baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen #(
    parameter int BAUD_DIV = 4 // clocks per oversampling tick
) (
    input  wire  i_clk,
    input  wire  i_reset,
    output logic o_tick
);

    // keep at least one bit even for a divisor of 1
    localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

    logic [CNT_W-1:0] div_cnt;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            div_cnt <= '0;
            o_tick  <= 1'b0;
        end else if (div_cnt == CNT_W'(BAUD_DIV - 1)) begin
            div_cnt <= '0;
            o_tick  <= 1'b1; // one cycle on wrap
        end else begin
            div_cnt <= div_cnt + 1'b1;
            o_tick  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_if;

    logic                  wr;      // write strobe
    uart_pkg::data_byte_t  wr_data;
    logic                  rd;      // read strobe, advances head
    uart_pkg::data_byte_t  rd_data; // always the head entry
    logic                  empty;
    logic                  full;

    // host side
    modport writer (
        output wr, wr_data,
        input  full, empty
    );

    // serializer side
    modport reader (
        output rd,
        input  rd_data, empty
    );

    modport fifo (
        input  wr, wr_data, rd,
        output rd_data, full, empty
    );

endinterface

`default_nettype wire

// File: uart_pkg.sv
`default_nettype none

package uart_pkg;

    // one character on the line
    typedef logic [7:0] data_byte_t;

    // oversampling ticks within one bit, 16 per bit
    typedef logic [3:0] tick_cnt_t;

    localparam int DATA_BITS = 8; // 8N1 only

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

`default_nettype wire
